//--- source/pkt_tag_pkg.sv
package pkt_tag_pkg;

    // Default flit width in bytes
    localparam int DATA_BYTES_DEF = 64;

    // Inserted tag, lead byte followed by the tag value
    localparam int          TAG_BYTES = 8;
    localparam logic [7:0]  TAG_LEAD  = 8'hff;

    // IPv4 protocol field, counted from the first packet byte
    localparam int          PROT_OFFSET = 23;
    localparam logic [7:0]  PROT_UDP    = 8'd17;

    typedef enum logic {
        CLASS_SHIFT,
        CLASS_BYPASS
    } pkt_class_e;

    typedef enum logic [1:0] {
        ST_PASS,
        ST_SHIFT,
        ST_TAIL
    } ins_state_e;

endpackage

//--- source/pkt_stream_if.sv
`timescale 1ns/10ps

interface pkt_stream_if
    import pkt_tag_pkg::*;
#(
    parameter int DATA_BYTES = DATA_BYTES_DEF
);

    logic                           sop;
    logic                           eop;
    logic                           valid;
    logic [DATA_BYTES*8-1:0]        data;
    // Unused bytes at the low end of the eop flit
    logic [$clog2(DATA_BYTES)-1:0]  empty;
    // Packet class, valid alongside the flit
    pkt_class_e                     cls;
    logic                           ready;

    modport source (
        output sop, eop, valid, data, empty, cls,
        input  ready
    );

    modport sink (
        input  sop, eop, valid, data, empty, cls,
        output ready
    );

endinterface

//--- source/pkt_classifier.sv
`timescale 1ns/10ps

module pkt_classifier
    import pkt_tag_pkg::*;
#(
    parameter int DATA_BYTES = DATA_BYTES_DEF
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_sop,
    input  logic                            in_eop,
    input  logic                            in_valid,
    input  logic [DATA_BYTES*8-1:0]         in_data,
    input  logic [$clog2(DATA_BYTES)-1:0]   in_empty,
    output logic                            in_ready,
    pkt_stream_if.source                    m
);

    // Byte 0 sits in the top lane
    localparam int PROT_LSB = (DATA_BYTES - 1 - PROT_OFFSET) * 8;

    logic [7:0]  prot_byte;
    pkt_class_e  sop_class;
    pkt_class_e  pkt_class_q;
    pkt_class_e  cur_class;
    logic        accept;

    assign in_ready = !m.valid || m.ready;
    assign accept   = in_valid && in_ready;

    assign prot_byte = in_data[PROT_LSB +: 8];
    assign sop_class = (prot_byte == PROT_UDP) ? CLASS_BYPASS : CLASS_SHIFT;
    assign cur_class = in_sop ? sop_class : pkt_class_q;

    // Class of the packet in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_class_q <= CLASS_BYPASS;
        end else if (accept && in_sop) begin
            pkt_class_q <= sop_class;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m.valid <= 1'b0;
        end else if (accept) begin
            m.valid <= 1'b1;
        end else if (m.ready) begin
            m.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m.sop   <= in_sop;
            m.eop   <= in_eop;
            m.data  <= in_data;
            m.empty <= in_empty;
            m.cls   <= cur_class;
        end
    end

    // Upstream must hold a stalled flit until it is taken
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data) && $stable(in_sop)
            && $stable(in_eop) && $stable(in_empty)
    );

endmodule

//--- source/tag_inserter.sv
`timescale 1ns/10ps

module tag_inserter
    import pkt_tag_pkg::*;
#(
    parameter int DATA_BYTES = DATA_BYTES_DEF
) (
    input  logic                            clk,
    input  logic                            rst_n,
    pkt_stream_if.sink                      s,
    input  logic [(TAG_BYTES-1)*8-1:0]      tag_value,
    output logic                            out_sop,
    output logic                            out_eop,
    output logic                            out_valid,
    output logic [DATA_BYTES*8-1:0]         out_data,
    output logic [$clog2(DATA_BYTES)-1:0]   out_empty,
    input  logic                            out_ready
);

    localparam int DATA_W  = DATA_BYTES * 8;
    localparam int TAG_W   = TAG_BYTES * 8;
    localparam int EMPTY_W = $clog2(DATA_BYTES);

    ins_state_e          state;
    logic [TAG_W-1:0]    carry;
    logic [EMPTY_W-1:0]  tail_empty;
    logic [TAG_W-1:0]    tag_word;
    logic [TAG_W-1:0]    head;
    logic                adv;
    logic                accept;
    logic                load;
    logic                is_shift;
    logic                spill;
    logic                nxt_sop;
    logic                nxt_eop;
    logic [DATA_W-1:0]   nxt_data;
    logic [EMPTY_W-1:0]  nxt_empty;

    // Output register free or draining this cycle
    assign adv = !out_valid || out_ready;

    assign s.ready = adv && (state != ST_TAIL);
    assign accept  = s.valid && s.ready;
    assign load    = accept || (state == ST_TAIL && adv);

    assign tag_word = {TAG_LEAD, tag_value};
    assign is_shift = (state == ST_SHIFT) || (s.sop && s.cls == CLASS_SHIFT);
    assign head     = (state == ST_SHIFT) ? carry : tag_word;

    // Last flit too full to absorb the displaced bytes
    assign spill = s.eop && (s.empty < EMPTY_W'(TAG_BYTES));

    always_comb begin
        nxt_sop   = s.sop;
        nxt_eop   = s.eop;
        nxt_data  = s.data;
        nxt_empty = s.empty;
        if (state == ST_TAIL) begin
            // Overflow flit, carried bytes then filler
            nxt_sop   = 1'b0;
            nxt_eop   = 1'b1;
            nxt_data  = {carry, {(DATA_W-TAG_W){1'b1}}};
            nxt_empty = tail_empty;
        end else if (is_shift) begin
            nxt_data = {head, s.data[DATA_W-1:TAG_W]};
            nxt_eop  = s.eop && !spill;
            if (s.eop && !spill) begin
                nxt_empty = s.empty - EMPTY_W'(TAG_BYTES);
            end else begin
                nxt_empty = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_PASS;
            carry     <= '0;
            out_valid <= 1'b0;
            out_eop   <= 1'b0;
        end else begin
            if (load) begin
                out_valid <= 1'b1;
                out_eop   <= nxt_eop;
            end else if (out_ready) begin
                out_valid <= 1'b0;
                out_eop   <= 1'b0;
            end

            if (state == ST_TAIL) begin
                if (adv) begin
                    state <= ST_PASS;
                end
            end else if (accept && is_shift) begin
                // Low lanes move on to the next flit
                carry <= s.data[TAG_W-1:0];
                if (!s.eop) begin
                    state <= ST_SHIFT;
                end else if (spill) begin
                    state <= ST_TAIL;
                end else begin
                    state <= ST_PASS;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_sop   <= nxt_sop;
            out_data  <= nxt_data;
            out_empty <= nxt_empty;
        end
        if (accept && is_shift && spill) begin
            tail_empty <= s.empty + EMPTY_W'(DATA_BYTES - TAG_BYTES);
        end
    end

    a_eop_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_eop |-> out_valid
    );

    // While the overflow flit waits, the shifted last flit is still held
    a_tail_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == ST_TAIL |-> !s.ready && out_valid && !out_eop
    );

endmodule

//--- source/pkt_tag_top.sv
`timescale 1ns/10ps

module pkt_tag_top
    import pkt_tag_pkg::*;
#(
    parameter int DATA_BYTES = DATA_BYTES_DEF
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_sop,
    input  logic                            in_eop,
    input  logic                            in_valid,
    input  logic [DATA_BYTES*8-1:0]         in_data,
    input  logic [$clog2(DATA_BYTES)-1:0]   in_empty,
    output logic                            in_ready,
    input  logic [(TAG_BYTES-1)*8-1:0]      tag_value,
    output logic                            out_sop,
    output logic                            out_eop,
    output logic                            out_valid,
    output logic [DATA_BYTES*8-1:0]         out_data,
    output logic [$clog2(DATA_BYTES)-1:0]   out_empty,
    input  logic                            out_ready
);

    // Protocol byte must land in the first flit
    if (DATA_BYTES < 32 || (DATA_BYTES & (DATA_BYTES - 1)) != 0) begin : g_bad_width
        $error("DATA_BYTES must be a power of two and at least 32");
    end

    pkt_stream_if #(.DATA_BYTES(DATA_BYTES)) cls_stream ();

    pkt_classifier #(.DATA_BYTES(DATA_BYTES)) i_classifier (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_sop   (in_sop),
        .in_eop   (in_eop),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_empty (in_empty),
        .in_ready (in_ready),
        .m        (cls_stream.source)
    );

    tag_inserter #(.DATA_BYTES(DATA_BYTES)) i_inserter (
        .clk       (clk),
        .rst_n     (rst_n),
        .s         (cls_stream.sink),
        .tag_value (tag_value),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_empty (out_empty),
        .out_ready (out_ready)
    );

endmodule

//--- testbench/pkt_tag_tb.sv
`timescale 1ns/10ps

module pkt_tag_tb;

    localparam int          DATA_BYTES      = 64;
    localparam int          EMPTY_W         = $clog2(DATA_BYTES);
    localparam int          CLK_PERIOD      = 10;
    localparam int          RESET_CYCLES    = 16;
    localparam int          NUM_PKTS        = 200;
    localparam int          TIMED_PKTS      = 20;
    localparam int          TAG_LEN         = 8;
    localparam int          WATCHDOG_CYCLES = (RESET_CYCLES + NUM_PKTS * 20) * 4;
    localparam logic [31:0] SEED            = 32'h48be_d02d;
    localparam logic [7:0]  UDP             = 8'd17;
    localparam logic [7:0]  LEAD            = 8'hff;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     in_sop;
    logic                     in_eop;
    logic                     in_valid;
    logic [DATA_BYTES*8-1:0]  in_data;
    logic [EMPTY_W-1:0]       in_empty;
    logic                     in_ready;
    logic [55:0]              tag_value;
    logic                     out_sop;
    logic                     out_eop;
    logic                     out_valid;
    logic [DATA_BYTES*8-1:0]  out_data;
    logic [EMPTY_W-1:0]       out_empty;
    logic                     out_ready;

    logic [31:0]  rng_stim  = SEED;
    logic [31:0]  rng_ready = ~SEED;
    logic         stall_on  = 1'b0;
    int           cycle     = 0;
    int           sops_seen = 0;
    int           pkts_done = 0;
    int           flits     = 0;
    bit           in_pkt    = 1'b0;

    // Reference model as a flat byte stream plus one length per packet
    logic [7:0]   exp_bytes[$];
    int           exp_len[$];
    int           sop_cycle[$];
    bit           timed_q[$];
    logic [7:0]   got[$];

    pkt_tag_top #(.DATA_BYTES(DATA_BYTES)) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_sop    (in_sop),
        .in_eop    (in_eop),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_empty  (in_empty),
        .in_ready  (in_ready),
        .tag_value (tag_value),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_empty (out_empty),
        .out_ready (out_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_stim();
        rng_stim = xorshift32(rng_stim);
        return rng_stim;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    task automatic end_packet();
        int len;
        len = exp_len.pop_front();
        check_value("packet length", 64'(got.size()), 64'(len));
        check_value("flit count", 64'(flits), 64'((len + DATA_BYTES - 1) / DATA_BYTES));
        check_value("out_empty", 64'(out_empty),
                    64'((DATA_BYTES - len % DATA_BYTES) % DATA_BYTES));
        for (int i = 0; i < len; i++) begin
            check_value($sformatf("out_data byte %0d of packet %0d", i, pkts_done),
                        64'(got[i]), 64'(exp_bytes.pop_front()));
        end
        got.delete();
        pkts_done++;
    endtask

    task automatic take_flit();
        int nbytes;
        int acc;
        bit timed;
        if (!in_pkt) begin
            if (exp_len.size() == 0) begin
                abort_run("Output packet appeared with no packet expected");
            end
            check_value("out_sop", 64'(out_sop), 64'd1);
            acc   = sop_cycle.pop_front();
            timed = timed_q.pop_front();
            if (timed) begin
                check_value("sop latency", 64'(cycle - acc), 64'd2);
            end
            sops_seen++;
            in_pkt = 1'b1;
            flits  = 0;
        end else begin
            check_value("out_sop", 64'(out_sop), 64'd0);
        end
        nbytes = out_eop ? DATA_BYTES - int'(out_empty) : DATA_BYTES;
        for (int i = 0; i < nbytes; i++) begin
            got.push_back(out_data[(DATA_BYTES-1-i)*8 +: 8]);
        end
        flits++;
        if (out_eop) begin
            end_packet();
            in_pkt = 1'b0;
        end
    endtask

    // Output monitor
    always @(posedge clk) begin
        if (!rst_n) begin
            // Flops settle at the first reset edge
            if (cycle != 0) begin
                check_value("out_valid", 64'(out_valid), 64'd0);
            end
        end else if (out_valid && out_ready) begin
            take_flit();
        end
    end

    task automatic send_packet(input int p, input bit timed);
        logic [7:0]               pkt[$];
        logic [DATA_BYTES*8-1:0]  word;
        logic [31:0]              r;
        int                       len;
        int                       nflits;
        int                       idx;
        r = rand_stim();
        // Short packets often enough to hit single flit overflow
        if (r[2:0] == 3'd0) begin
            len = 24 + int'(rand_stim() % 41);
        end else begin
            len = 24 + int'(rand_stim() % 277);
        end
        for (int b = 0; b < len; b++) begin
            r = rand_stim();
            pkt.push_back(r[7:0]);
        end
        r = rand_stim();
        if (r[0]) begin
            pkt[23] = UDP;
        end else if (pkt[23] == UDP) begin
            pkt[23] = 8'd6;
        end
        // Tag changes only once every earlier sop is past the inserter
        if (p % 4 == 0) begin
            while (sops_seen != p) begin
                @(posedge clk);
                #1;
            end
            r = rand_stim();
            tag_value = {r[23:0], rand_stim()};
        end
        if (pkt[23] != UDP) begin
            exp_bytes.push_back(LEAD);
            for (int k = 6; k >= 0; k--) begin
                exp_bytes.push_back(tag_value[k*8 +: 8]);
            end
        end
        for (int b = 0; b < len; b++) begin
            exp_bytes.push_back(pkt[b]);
        end
        exp_len.push_back(pkt[23] == UDP ? len : len + TAG_LEN);
        nflits = (len + DATA_BYTES - 1) / DATA_BYTES;
        for (int f = 0; f < nflits; f++) begin
            r = rand_stim();
            if (!timed && r[1:0] == 2'b00) begin
                repeat (int'(r[3:2]) + 1) begin
                    @(posedge clk);
                    #1;
                end
            end
            for (int i = 0; i < DATA_BYTES; i++) begin
                idx = f * DATA_BYTES + i;
                word[(DATA_BYTES-1-i)*8 +: 8] = (idx < len) ? pkt[idx] : 8'h00;
            end
            in_data  = word;
            in_sop   = (f == 0);
            in_eop   = (f == nflits - 1);
            in_empty = in_eop ? EMPTY_W'(nflits * DATA_BYTES - len) : '0;
            in_valid = 1'b1;
            @(posedge clk);
            while (!in_ready) begin
                @(posedge clk);
            end
            if (f == 0) begin
                sop_cycle.push_back(cycle);
                timed_q.push_back(timed);
            end
            #1;
            in_valid = 1'b0;
            in_sop   = 1'b0;
            in_eop   = 1'b0;
        end
        // Let the pipeline drain so the next latency sample is clean
        if (timed) begin
            repeat (3) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // Output back-pressure
    initial begin
        bit stall_now;
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            stall_now = stall_on;
            #1;
            if (stall_now) begin
                rng_ready = xorshift32(rng_ready);
                out_ready = (rng_ready[1:0] != 2'b00);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("Timeout: the packets did not all come out in time");
    end

    initial begin
        rst_n     = 1'b0;
        in_sop    = 1'b0;
        in_eop    = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_empty  = '0;
        tag_value = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        for (int p = 0; p < NUM_PKTS; p++) begin
            if (p == TIMED_PKTS) begin
                stall_on = 1'b1;
            end
            send_packet(p, p < TIMED_PKTS);
        end
        while (pkts_done != NUM_PKTS) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (exp_len.size() == 0 && exp_bytes.size() == 0 && !out_valid) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort_run("Output stream did not end cleanly after the last packet");
        end
    end

endmodule

//--- pkt_tag_top.f
source/pkt_tag_pkg.sv
source/pkt_stream_if.sv
source/pkt_classifier.sv
source/tag_inserter.sv
source/pkt_tag_top.sv
testbench/pkt_tag_tb.sv

//--- Makefile
# Verilator build and run for the packet tag inserter
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= pkt_tag_tb
FILELIST  ?= pkt_tag_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv) $(wildcard testbench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx '=== PASS ===' $(LOG); then \
		echo "Result: test passed"; \
	else \
		echo "Result: test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
